// File: kbd_pkg.sv
package kbd_pkg;

    // scan code sent ahead of the code of a released key
    localparam logic [7:0] BREAK_CODE = 8'hF0;

    // hex digits on the display, digit 0 shows the low nibble
    localparam int NUM_DIGITS = 2;

    // seven segments plus decimal point
    localparam int SEG_W = 8;

    // flops on each PS/2 line before use
    localparam int SYNC_STAGES = 3;

    // make/break tracker states
    typedef enum logic [1:0]
    {
        IDLE,        // waiting for the first byte of a sequence
        MAKE_SEEN,   // plain make code taken, one cycle
        BREAK_SEEN,  // break prefix taken, waiting for the code
        CAPTURE      // released code latched, strobe high
    } key_state_t;

endpackage

// File: ps2_byte_if.sv
`timescale 1ns/1ps

interface ps2_byte_if;

    logic [7:0] data;
    logic       valid;
    logic       ready;
    logic       frame_err;  // one cycle per rejected frame

    modport source
    (
        output data,
        output valid,
        output frame_err,
        input  ready
    );

    modport sink
    (
        input  data,
        input  valid,
        input  frame_err,
        output ready
    );

endinterface

// File: ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    ps2_byte_if.source byte_out
);

    import kbd_pkg::*;

    logic [SYNC_STAGES-1:0] clk_sync;
    logic [SYNC_STAGES-1:0] dat_sync;
    logic                   clk_last;
    logic                   fall;
    logic [3:0]             bit_cnt;
    logic [10:0]            frame_q;
    logic [10:0]            frame_next;
    logic                   frame_done;
    logic                   frame_good;
    logic                   load;
    logic [7:0]             hold_q;
    logic                   valid_q;
    logic                   err_q;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;  // idle lines are high
            dat_sync <= '1;
            clk_last <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC_STAGES-2:0], ps2_dat};
            clk_last <= clk_sync[SYNC_STAGES-1];
        end
    end

    assign fall = clk_last & ~clk_sync[SYNC_STAGES-1];

    // bits enter at the top, so the start bit ends up in bit 0
    assign frame_next = {dat_sync[SYNC_STAGES-1], frame_q[10:1]};
    assign frame_done = fall && (bit_cnt == 4'd10);
    assign frame_good = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);  // odd parity
    assign load       = frame_done && frame_good && (!valid_q || byte_out.ready);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt <= 4'd0;
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end
        else
        begin
            err_q <= frame_done && !frame_good;
            if (fall)
            begin
                bit_cnt <= (bit_cnt == 4'd10) ? 4'd0 : bit_cnt + 4'd1;
            end
            if (load)
            begin
                valid_q <= 1'b1;
            end
            else if (valid_q && byte_out.ready)
            begin
                valid_q <= 1'b0;  // byte taken
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
        begin
            frame_q <= frame_next;
        end
        if (load)
        begin
            hold_q <= frame_next[8:1];
        end
    end

    assign byte_out.data      = hold_q;
    assign byte_out.valid     = valid_q;
    assign byte_out.frame_err = err_q;

    // the held byte may not change before the tracker takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
        (byte_out.valid && !byte_out.ready) |=> $stable(byte_out.data));

    a_err_not_valid: assert property (@(posedge clk) disable iff (!rst)
        !(byte_out.frame_err && $rose(byte_out.valid)));

    // a new frame while the tracker stalls would be lost
    a_no_drop: assert property (@(posedge clk) disable iff (!rst)
        !(frame_done && frame_good && valid_q && !byte_out.ready));

endmodule

// File: key_release_fsm.sv
`timescale 1ns/1ps

module key_release_fsm
(
    input  logic                                clk,
    input  logic                                rst,
    ps2_byte_if.sink                            byte_in,
    output logic [kbd_pkg::NUM_DIGITS-1:0][3:0] nibbles,
    output logic                                blank,
    output logic                                key_strobe
);

    import kbd_pkg::*;

    key_state_t                  state;
    key_state_t                  state_next;
    logic                        xfer;
    logic [NUM_DIGITS-1:0][3:0]  key_q;
    logic                        blank_q;

    assign byte_in.ready = (state == IDLE) || (state == BREAK_SEEN);
    assign xfer          = byte_in.valid && byte_in.ready;

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (xfer)
                begin
                    state_next = (byte_in.data == BREAK_CODE) ? BREAK_SEEN : MAKE_SEEN;
                end
            end
            MAKE_SEEN:  state_next = IDLE;
            BREAK_SEEN:
            begin
                if (byte_in.frame_err)
                begin
                    state_next = IDLE;  // sequence broken, start over
                end
                else if (xfer && byte_in.data != BREAK_CODE)
                begin
                    state_next = CAPTURE;
                end
            end
            CAPTURE:    state_next = IDLE;
            default:    state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state   <= IDLE;
            blank_q <= 1'b1;
        end
        else
        begin
            state <= state_next;
            if (state_next == CAPTURE)
            begin
                blank_q <= 1'b0;
            end
        end
    end

    // released code lands together with the move into CAPTURE
    always_ff @(posedge clk)
    begin
        if (state == BREAK_SEEN && state_next == CAPTURE)
        begin
            key_q <= byte_in.data;
        end
    end

    assign nibbles    = key_q;
    assign blank      = blank_q;
    assign key_strobe = (state == CAPTURE);

    a_strobe_single: assert property (@(posedge clk) disable iff (!rst)
        key_strobe |=> !key_strobe);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst)
        state inside {IDLE, MAKE_SEEN, BREAK_SEEN, CAPTURE});

endmodule

// File: hex_digit_seg.sv
`timescale 1ns/1ps

module hex_digit_seg
(
    input  logic [3:0]                nibble,
    input  logic                      blank,
    output logic [kbd_pkg::SEG_W-1:0] seg
);

    import kbd_pkg::*;

    logic [SEG_W-1:0] pattern;

    // bit 7 is dp, bits 6..0 are g..a, low means lit
    always_comb
    begin
        case (nibble)
            4'h0:    pattern = 8'hC0;
            4'h1:    pattern = 8'hF9;
            4'h2:    pattern = 8'hA4;
            4'h3:    pattern = 8'hB0;
            4'h4:    pattern = 8'h99;
            4'h5:    pattern = 8'h92;
            4'h6:    pattern = 8'h82;
            4'h7:    pattern = 8'hF8;
            4'h8:    pattern = 8'h80;
            4'h9:    pattern = 8'h90;
            4'hA:    pattern = 8'h88;
            4'hB:    pattern = 8'h83;  // lower case b
            4'hC:    pattern = 8'hC6;
            4'hD:    pattern = 8'hA1;  // lower case d
            4'hE:    pattern = 8'h86;
            4'hF:    pattern = 8'h8E;
            default: pattern = '1;
        endcase
    end

    assign seg = blank ? '1 : pattern;

endmodule

// File: kbd_display_top.sv
`timescale 1ns/1ps

module kbd_display_top
(
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            ps2_clk,
    input  logic                                            ps2_dat,
    output logic [kbd_pkg::NUM_DIGITS*kbd_pkg::SEG_W-1:0]   seg_out,
    output logic                                            key_strobe
);

    import kbd_pkg::*;

    logic [NUM_DIGITS-1:0][3:0] nibbles;
    logic                       blank;

    ps2_byte_if byte_if ();

    ps2_rx ps2_rx_inst
    (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .byte_out (byte_if.source)
    );

    key_release_fsm key_release_fsm_inst
    (
        .clk        (clk),
        .rst        (rst),
        .byte_in    (byte_if.sink),
        .nibbles    (nibbles),
        .blank      (blank),
        .key_strobe (key_strobe)
    );

    // digit 0 takes the low nibble and the low byte of seg_out
    for (genvar i = 0; i < NUM_DIGITS; i++)
    begin : g_digit
        hex_digit_seg hex_digit_seg_inst
        (
            .nibble (nibbles[i]),
            .blank  (blank),
            .seg    (seg_out[i*SEG_W +: SEG_W])
        );
    end

endmodule

// File: tb_kbd_display.sv
`timescale 1ns/1ps

module tb_kbd_display;

    import kbd_pkg::*;

    localparam int PS2_HALF   = 20;   // clk cycles per PS/2 clock phase
    localparam int FRAME_GAP  = 8;
    localparam int NUM_FRAMES = 97;   // 4 make, 80 release, 6 parity, 7 sequence frames
    localparam int CYCLE_LIMIT = NUM_FRAMES * 11 * 40 + 2000;
    localparam int STROBE_WAIT = 100;

    logic                          clk;
    logic                          rst;
    logic                          ps2_clk;
    logic                          ps2_dat;
    logic [NUM_DIGITS*SEG_W-1:0]   seg_out;
    logic                          key_strobe;

    logic [31:0] rng;
    logic [7:0]  exp_key;
    bit          key_shown;
    int          strobe_cnt;
    int          value_errs;
    int          strobe_errs;
    int          cycle_cnt;

    kbd_display_top kbd_display_top_inst
    (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .seg_out    (seg_out),
        .key_strobe (key_strobe)
    );

    always #20 clk = ~clk;

    // expected display for a key code, all segments off while nothing was released
    function automatic logic [NUM_DIGITS*SEG_W-1:0] ref_seg(input logic [7:0] key,
                                                             input bit shown);
        logic [NUM_DIGITS*SEG_W-1:0] result;
        logic [3:0]                  nib;
        logic [SEG_W-1:0]            pat;
        int                          d;
        result = '1;
        for (d = 0; d < NUM_DIGITS; d++)
        begin
            nib = key[d*4 +: 4];
            case (nib)
                4'h0: pat = 8'hC0;
                4'h1: pat = 8'hF9;
                4'h2: pat = 8'hA4;
                4'h3: pat = 8'hB0;
                4'h4: pat = 8'h99;
                4'h5: pat = 8'h92;
                4'h6: pat = 8'h82;
                4'h7: pat = 8'hF8;
                4'h8: pat = 8'h80;
                4'h9: pat = 8'h90;
                4'hA: pat = 8'h88;
                4'hB: pat = 8'h83;
                4'hC: pat = 8'hC6;
                4'hD: pat = 8'hA1;
                4'hE: pat = 8'h86;
                default: pat = 8'h8E;
            endcase
            if (shown)
            begin
                result[d*SEG_W +: SEG_W] = pat;
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_code(output logic [7:0] k);
        do
        begin
            rng = lcg_next(rng);
            k   = rng[31:24];  // upper bits have the longest period
        end
        while (k == BREAK_CODE);
    endtask

    // start, data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input bit bad_parity);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        @(negedge clk);
        for (i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b1;
        end
        repeat (FRAME_GAP) @(negedge clk);
    endtask

    task automatic check_display();
        @(negedge clk);
        assert (seg_out == ref_seg(exp_key, key_shown))
        else
        begin
            $display("[ERROR] seg_out expected %h got %h", ref_seg(exp_key, key_shown), seg_out);
            value_errs++;
        end
    endtask

    task automatic check_no_strobe(input int count, input logic [7:0] code);
        assert (strobe_cnt == count)
        else
        begin
            $display("unexpected key_strobe after code %h", code);
            strobe_errs++;
        end
    endtask

    task automatic wait_strobe(input int target, input logic [7:0] code);
        int n;
        n = 0;
        while (strobe_cnt < target && n < STROBE_WAIT)
        begin
            @(posedge clk);
            n++;
        end
        assert (strobe_cnt == target)
        else
        begin
            if (strobe_cnt < target)
                $display("no key_strobe after the break sequence for key %h", code);
            else
                $display("more than one key_strobe for key %h", code);
            strobe_errs++;
        end
    endtask

    task automatic release_key(input logic [7:0] k);
        int start;
        start = strobe_cnt;
        send_frame(BREAK_CODE, 1'b0);
        exp_key   = k;
        key_shown = 1'b1;
        send_frame(k, 1'b0);
        wait_strobe(start + 1, k);
        check_display();
    endtask

    task automatic press_only(input logic [7:0] k, input bit bad_parity);
        int start;
        start = strobe_cnt;
        send_frame(k, bad_parity);
        check_no_strobe(start, k);
        check_display();
    endtask

    always @(negedge clk)
    begin
        if (rst && key_strobe)
        begin
            strobe_cnt++;
            assert (seg_out == ref_seg(exp_key, 1'b1))
            else
            begin
                $display("[ERROR] seg_out key %h expected %h got %h",
                         exp_key, ref_seg(exp_key, 1'b1), seg_out);
                value_errs++;
            end
        end
    end

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("run hit its limit of %0d cycles before the tests ended", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial
    begin
        logic [7:0] k;
        logic [7:0] k2;
        int         i;
        int         start;
        clk         = 1'b0;
        rst         = 1'b0;
        ps2_clk     = 1'b1;
        ps2_dat     = 1'b1;
        rng         = 32'h11373eff;
        exp_key     = 8'h00;
        key_shown   = 1'b0;
        strobe_cnt  = 0;
        value_errs  = 0;
        strobe_errs = 0;
        repeat (10) @(negedge clk);
        rst = 1'b1;

        check_display();  // blank after reset
        check_no_strobe(0, 8'h00);

        for (i = 0; i < 4; i++)
        begin
            draw_code(k);
            press_only(k, 1'b0);
        end

        for (i = 0; i < 40; i++)
        begin
            draw_code(k);
            release_key(k);
        end

        draw_code(k);
        press_only(k, 1'b1);  // bad parity while idle

        start = strobe_cnt;
        send_frame(BREAK_CODE, 1'b0);
        draw_code(k);
        send_frame(k, 1'b1);
        draw_code(k2);
        send_frame(k2, 1'b0);  // taken as a make code now
        check_no_strobe(start, k2);
        check_display();
        draw_code(k);
        release_key(k);

        start = strobe_cnt;
        send_frame(BREAK_CODE, 1'b0);
        send_frame(BREAK_CODE, 1'b0);
        send_frame(BREAK_CODE, 1'b0);
        draw_code(k);
        exp_key = k;
        send_frame(k, 1'b0);
        wait_strobe(start + 1, k);
        check_display();

        draw_code(k);
        press_only(k, 1'b0);  // typed key, make then release
        release_key(k);

        repeat (FRAME_GAP) @(negedge clk);
        $display("errors: seg_out %0d, strobe %0d, total %0d",
                 value_errs, strobe_errs, value_errs + strobe_errs);
        if (value_errs + strobe_errs == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
kbd_pkg.sv
ps2_byte_if.sv
ps2_rx.sv
key_release_fsm.sv
hex_digit_seg.sv
kbd_display_top.sv
tb_kbd_display.sv

// File: Bender.yml
package:
  name: kbd_display

sources:
  - kbd_pkg.sv
  - ps2_byte_if.sv
  - ps2_rx.sv
  - key_release_fsm.sv
  - hex_digit_seg.sv
  - kbd_display_top.sv
  - target: test
    files:
      - tb_kbd_display.sv
